// ==== hw/cw_io_pkg.sv ====
package cw_io_pkg;

   // bus and block sizes
   localparam int BYTECNT_W    = 7;
   localparam int NUM_LANES    = 4;  // target io lines
   localparam int NUM_TRIG_SRC = 6;  // aux, nrst, io1..io4

   // register map
   localparam logic [7:0] ADDR_TRIGSRC = 8'd39;
   localparam logic [7:0] ADDR_TRIGMOD = 8'd40;
   localparam logic [7:0] ADDR_IOROUTE = 8'd55;  // 8 bytes, indexed by bytecnt
   localparam logic [7:0] ADDR_IOREAD  = 8'd56;  // sampled line levels, read only

   // reset values
   localparam logic [7:0]  TRIGSRC_RST = 8'h20;  // R4 only, OR combine
   localparam logic [7:0]  TRIGMOD_RST = 8'h00;  // plain edge trigger
   localparam logic [63:0] IOROUTE_RST = 64'h0000_0000_0000_0201;  // io1 tx, io2 rx

   // extra byte of the routing register
   localparam int IOROUTE_EXTRA_BYTE = 5;
   localparam int PWROFF_BIT         = 1;  // target power disable

   // trigger combine modes
   localparam logic [1:0] COMB_OR   = 2'd0;
   localparam logic [1:0] COMB_AND  = 2'd1;
   localparam logic [1:0] COMB_NAND = 2'd2;
   localparam logic [1:0] COMB_LOW  = 2'd3;  // constant low

   // external trigger source config
   typedef struct packed {
      logic [1:0]              comb_mode;  // see COMB_*
      logic [NUM_TRIG_SRC-1:0] src_en;     // bit 0 aux, 1 nrst, 2..5 io1..io4
   } trig_src_cfg_t;

   // trigger module select
   typedef enum logic [2:0] {
      EDGE_EXT   = 3'd0,
      ADV_IO     = 3'd1,
      SAD        = 3'd2,
      DECODED_IO = 3'd3,
      TRACE      = 3'd4,
      ADC_LEVEL  = 3'd5
   } trig_mode_e;  // 6 and 7 give constant low

   typedef struct packed {
      logic [4:0] spare;
      trig_mode_e mode;
   } trig_mod_cfg_t;

   // one lane's routing byte, msb first
   typedef struct packed {
      logic gpio_en;    // drive gpio_val
      logic gpio_val;
      logic txo;        // kept for sw compatibility, no effect
      logic usoc;       // open collector tx
      logic force_low;
      logic spare;
      logic rx_sel;     // line feeds uart rx
      logic tx_sel;     // line driven by uart tx
   } io_route_t;

   // pin drive towards the pad
   typedef struct packed {
      logic oe;   // output enable
      logic val;  // output value
   } pin_drive_t;

   // internal trigger module outputs
   typedef struct packed {
      logic adv_io;
      logic sad;
      logic decoded_io;
      logic trace;
      logic adc;
   } trig_in_t;

endpackage

// ==== hw/cw_regs.sv ====
`timescale 1ns/1ps

module cw_regs (
   input  logic                                           clk_usb,
   input  logic                                           reset,
   input  logic [7:0]                                     reg_address_i,
   input  logic [cw_io_pkg::BYTECNT_W-1:0]                reg_bytecnt_i,
   input  logic [7:0]                                     reg_datai_i,
   input  logic                                           reg_read_i,
   input  logic                                           reg_write_i,
   input  logic [cw_io_pkg::NUM_LANES-1:0]                ioread_i,     // sampled levels
   output logic [7:0]                                     reg_datao_o,
   output cw_io_pkg::trig_src_cfg_t                       trig_src_o,
   output cw_io_pkg::trig_mod_cfg_t                       trig_mod_o,
   output cw_io_pkg::io_route_t [cw_io_pkg::NUM_LANES-1:0] io_route_o,
   output logic                                           power_off_o   // one flop after reg
);

   cw_io_pkg::trig_src_cfg_t trigsrc_q;
   cw_io_pkg::trig_mod_cfg_t trigmod_q;
   logic [63:0]              ioroute_q;    // 8 routing bytes
   logic                     power_off_q;

   logic       route_byte_ok;  // bytecnt inside the 8 byte register
   logic [2:0] route_byte;
   logic [5:0] route_bit;      // lsb of the selected byte

   assign route_byte_ok = (reg_bytecnt_i < 8);
   assign route_byte    = reg_bytecnt_i[2:0];
   assign route_bit     = {route_byte, 3'b000};

   // register writes, single cycle
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         trigsrc_q <= cw_io_pkg::trig_src_cfg_t'(cw_io_pkg::TRIGSRC_RST);
         trigmod_q <= cw_io_pkg::trig_mod_cfg_t'(cw_io_pkg::TRIGMOD_RST);
         ioroute_q <= cw_io_pkg::IOROUTE_RST;
      end else if (reg_write_i) begin
         case (reg_address_i)
            cw_io_pkg::ADDR_TRIGSRC: begin
               trigsrc_q <= cw_io_pkg::trig_src_cfg_t'(reg_datai_i);
            end
            cw_io_pkg::ADDR_TRIGMOD: begin
               trigmod_q <= cw_io_pkg::trig_mod_cfg_t'(reg_datai_i);
            end
            cw_io_pkg::ADDR_IOROUTE: begin
               if (route_byte_ok) begin
                  ioroute_q[route_bit +: 8] <= reg_datai_i;  // byte lane by bytecnt
               end
            end
            default: ;  // unknown or read-only, dropped
         endcase
      end
   end

   // target power gets its own flop
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         power_off_q <= 1'b0;
      end else begin
         power_off_q <= ioroute_q[cw_io_pkg::IOROUTE_EXTRA_BYTE*8 + cw_io_pkg::PWROFF_BIT];
      end
   end

   // read mux, zero when not reading
   always_comb begin
      reg_datao_o = 8'h00;
      if (reg_read_i) begin
         case (reg_address_i)
            cw_io_pkg::ADDR_TRIGSRC: begin
               reg_datao_o = trigsrc_q;
            end
            cw_io_pkg::ADDR_TRIGMOD: begin
               reg_datao_o = trigmod_q;
            end
            cw_io_pkg::ADDR_IOROUTE: begin
               if (route_byte_ok) begin
                  reg_datao_o = ioroute_q[route_bit +: 8];
               end
            end
            cw_io_pkg::ADDR_IOREAD: begin
               reg_datao_o[cw_io_pkg::NUM_LANES-1:0] = ioread_i;  // upper bits stay 0
            end
            default: ;
         endcase
      end
   end

   // config out to trigger and lanes
   assign trig_src_o  = trigsrc_q;
   assign trig_mod_o  = trigmod_q;
   assign io_route_o  = ioroute_q[cw_io_pkg::NUM_LANES*8-1:0];  // lane 1 in byte 0
   assign power_off_o = power_off_q;

   // bus is either read or write in a cycle
   a_no_rd_wr: assert property (
      @(posedge clk_usb) disable iff (reset)
      !(reg_read_i && reg_write_i)
   ) else $error("cw_regs: read and write in the same cycle");

   // routing register is only 8 bytes deep
   a_route_bytecnt: assert property (
      @(posedge clk_usb) disable iff (reset)
      ((reg_read_i || reg_write_i) && (reg_address_i == cw_io_pkg::ADDR_IOROUTE))
         |-> (reg_bytecnt_i <= 7)
   ) else $error("cw_regs: ioroute byte count %0d out of range", reg_bytecnt_i);

endmodule

// ==== hw/trigger_route.sv ====
`timescale 1ns/1ps

module trigger_route (
   input  cw_io_pkg::trig_src_cfg_t trig_src_i,
   input  cw_io_pkg::trig_mod_cfg_t trig_mod_i,
   input  logic                     aux_trig_i,      // source bit 0
   input  logic                     trigger_nrst_i,  // source bit 1
   input  logic [3:0]               trigger_io_i,    // sources 2..5
   input  cw_io_pkg::trig_in_t      trig_in_i,       // internal trigger modules
   output logic                     trigger_o,
   output logic                     trigger_ext_o,
   output logic                     decodeio_active_o,
   output logic                     sad_active_o
);

   logic [cw_io_pkg::NUM_TRIG_SRC-1:0] src;
   logic [cw_io_pkg::NUM_TRIG_SRC-1:0] mask;
   logic                               trig_or;
   logic                               trig_and;

   assign src  = {trigger_io_i, trigger_nrst_i, aux_trig_i};
   assign mask = trig_src_i.src_en;

   assign trig_or  = |(mask & src);   // any enabled source high
   assign trig_and = &(src | ~mask);  // disabled sources count as high

   // combine the external sources
   always_comb begin
      case (trig_src_i.comb_mode)
         cw_io_pkg::COMB_OR:   trigger_ext_o = trig_or;
         cw_io_pkg::COMB_AND:  trigger_ext_o = trig_and;
         cw_io_pkg::COMB_NAND: trigger_ext_o = ~trig_and;
         default:              trigger_ext_o = 1'b0;  // COMB_LOW
      endcase
   end

   // trigger module select
   always_comb begin
      case (trig_mod_i.mode)
         cw_io_pkg::EDGE_EXT:   trigger_o = trigger_ext_o;
         cw_io_pkg::ADV_IO:     trigger_o = trig_in_i.adv_io;
         cw_io_pkg::SAD:        trigger_o = trig_in_i.sad;
         cw_io_pkg::DECODED_IO: trigger_o = trig_in_i.decoded_io;
         cw_io_pkg::TRACE:      trigger_o = trig_in_i.trace;
         cw_io_pkg::ADC_LEVEL:  trigger_o = trig_in_i.adc;
         default:               trigger_o = 1'b0;  // 6, 7 unused
      endcase
   end

   // tell the decoder and sad blocks they own the trigger
   assign decodeio_active_o = (trig_mod_i.mode == cw_io_pkg::DECODED_IO);
   assign sad_active_o      = (trig_mod_i.mode == cw_io_pkg::SAD);

   // unmapped modes must never fire the capture
   a_mode_hi_low: assert final ((trig_mod_i.mode <= 3'd5) || !trigger_o)
      else $error("trigger_route: trigger high with mode %0d", trig_mod_i.mode);

endmodule

// ==== hw/target_io_lane.sv ====
`timescale 1ns/1ps

module target_io_lane (
   input  logic                   clk_usb,
   input  logic                   reset,
   input  cw_io_pkg::io_route_t   cfg_i,        // this lane's routing byte
   input  logic                   power_off_i,  // target unpowered, hi-z all
   input  logic                   uart_tx_i,
   input  logic                   pin_level_i,  // resolved pad level
   output cw_io_pkg::pin_drive_t  pin_o,
   output logic                   rx_req_o,
   output logic                   level_q_o
);

   // drive priority: power, tx, force low, open collector, gpio
   always_comb begin
      pin_o.oe  = 1'b0;  // released by default
      pin_o.val = 1'b0;
      if (power_off_i) begin
         pin_o.oe = 1'b0;
      end else if (cfg_i.tx_sel) begin
         pin_o.oe  = 1'b1;
         pin_o.val = uart_tx_i;
      end else if (cfg_i.force_low) begin
         pin_o.oe  = 1'b1;
         pin_o.val = 1'b0;
      end else if (cfg_i.usoc) begin
         pin_o.oe  = ~uart_tx_i;  // pull low on 0, let go on 1
         pin_o.val = 1'b0;
      end else if (cfg_i.gpio_en) begin
         pin_o.oe  = 1'b1;
         pin_o.val = cfg_i.gpio_val;
      end
   end

   // rx candidate, arbitration done in gather
   assign rx_req_o = cfg_i.rx_sel;

   // level sample for register read-back
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         level_q_o <= 1'b0;
      end else begin
         level_q_o <= pin_level_i;
      end
   end

   // power off must hold off drive the whole time the flop says so
   a_off_no_drive: assert property (
      @(posedge clk_usb) disable iff (reset)
      power_off_i |-> !pin_o.oe
   ) else $error("target_io_lane: output enabled while target power off");

endmodule

// ==== hw/io_gather.sv ====
`timescale 1ns/1ps

module io_gather (
   input  logic [cw_io_pkg::NUM_LANES-1:0] rx_req_i,   // rx_sel per lane
   input  logic [cw_io_pkg::NUM_LANES-1:0] level_i,    // live pad levels
   input  logic [cw_io_pkg::NUM_LANES-1:0] level_q_i,  // sampled levels
   output logic                            uart_rx_o,
   output logic [cw_io_pkg::NUM_LANES-1:0] ioread_o
);

   // lowest numbered lane wins, idle high when none selected
   always_comb begin
      uart_rx_o = 1'b1;
      for (int i = cw_io_pkg::NUM_LANES - 1; i >= 0; i--) begin
         if (rx_req_i[i]) begin
            uart_rx_o = level_i[i];  // later hit is a lower lane
         end
      end
   end

   // lane 1 in bit 0 for read-back
   always_comb begin
      ioread_o = '0;
      for (int i = 0; i < cw_io_pkg::NUM_LANES; i++) begin
         ioread_o[i] = level_q_i[i];
      end
   end

endmodule

// ==== hw/cw_io_top.sv ====
`timescale 1ns/1ps

module cw_io_top (
   input  logic                                            clk_usb,
   input  logic                                            reset,
   // register bus
   input  logic [7:0]                                      reg_address_i,
   input  logic [cw_io_pkg::BYTECNT_W-1:0]                 reg_bytecnt_i,
   input  logic [7:0]                                      reg_datai_i,
   input  logic                                            reg_read_i,
   input  logic                                            reg_write_i,
   output logic [7:0]                                      reg_datao_o,
   // trigger
   input  logic                                            aux_trig_i,
   input  logic                                            trigger_nrst_i,
   input  logic [3:0]                                      trigger_io_i,
   input  cw_io_pkg::trig_in_t                             trig_in_i,
   output logic                                            trigger_o,
   output logic                                            trigger_ext_o,
   output logic                                            decodeio_active_o,
   output logic                                            sad_active_o,
   // uart
   input  logic                                            uart_tx_i,
   output logic                                            uart_rx_o,
   // target io pins
   output cw_io_pkg::pin_drive_t [cw_io_pkg::NUM_LANES-1:0] pin_o,
   input  logic [cw_io_pkg::NUM_LANES-1:0]                 pin_level_i,
   output logic                                            targetpower_off_o
);

   cw_io_pkg::trig_src_cfg_t                        trig_src;
   cw_io_pkg::trig_mod_cfg_t                        trig_mod;
   cw_io_pkg::io_route_t [cw_io_pkg::NUM_LANES-1:0] io_route;
   logic                                            power_off;
   logic [cw_io_pkg::NUM_LANES-1:0]                 rx_req;
   logic [cw_io_pkg::NUM_LANES-1:0]                 level_q;
   logic [cw_io_pkg::NUM_LANES-1:0]                 ioread;

   cw_regs i_cw_regs (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .reg_address_i (reg_address_i),
      .reg_bytecnt_i (reg_bytecnt_i),
      .reg_datai_i   (reg_datai_i),
      .reg_read_i    (reg_read_i),
      .reg_write_i   (reg_write_i),
      .ioread_i      (ioread),
      .reg_datao_o   (reg_datao_o),
      .trig_src_o    (trig_src),
      .trig_mod_o    (trig_mod),
      .io_route_o    (io_route),
      .power_off_o   (power_off)
   );

   trigger_route i_trigger_route (
      .trig_src_i        (trig_src),
      .trig_mod_i        (trig_mod),
      .aux_trig_i        (aux_trig_i),
      .trigger_nrst_i    (trigger_nrst_i),
      .trigger_io_i      (trigger_io_i),
      .trig_in_i         (trig_in_i),
      .trigger_o         (trigger_o),
      .trigger_ext_o     (trigger_ext_o),
      .decodeio_active_o (decodeio_active_o),
      .sad_active_o      (sad_active_o)
   );

   // one lane per target io line
   for (genvar g = 0; g < cw_io_pkg::NUM_LANES; g++) begin : g_lane
      target_io_lane i_lane (
         .clk_usb     (clk_usb),
         .reset       (reset),
         .cfg_i       (io_route[g]),
         .power_off_i (power_off),
         .uart_tx_i   (uart_tx_i),
         .pin_level_i (pin_level_i[g]),
         .pin_o       (pin_o[g]),
         .rx_req_o    (rx_req[g]),
         .level_q_o   (level_q[g])
      );
   end

   io_gather i_io_gather (
      .rx_req_i  (rx_req),
      .level_i   (pin_level_i),  // rx sees the live pad
      .level_q_i (level_q),
      .uart_rx_o (uart_rx_o),
      .ioread_o  (ioread)
   );

   assign targetpower_off_o = power_off;

endmodule

// ==== sim/tb_cw_io_checks.svh ====
`ifndef TB_CW_IO_CHECKS_SVH
`define TB_CW_IO_CHECKS_SVH

// running totals for the per-test lines and the closing line
int check_count = 0;
int err_count   = 0;
int test_count  = 0;

// register read data
task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
   check_count++;
   if (act !== exp) begin
      err_count++;
      $display("mismatch %s: expected %02h, actual %02h", name, exp, act);
   end
endtask

// {trigger, trigger_ext, decodeio_active, sad_active}
task automatic check_trig(input string name, input logic [3:0] exp, input logic [3:0] act);
   check_count++;
   if (act !== exp) begin
      err_count++;
      $display("mismatch %s: expected trig/ext/dec/sad %04b, actual %04b", name, exp, act);
   end
endtask

// value only matters while the lane drives
task automatic check_pin(input string name, input cw_io_pkg::pin_drive_t exp,
                         input cw_io_pkg::pin_drive_t act);
   check_count++;
   if (act.oe !== exp.oe || (exp.oe && act.val !== exp.val)) begin
      err_count++;
      $display("mismatch %s: expected oe %0b val %0b, actual oe %0b val %0b",
               name, exp.oe, exp.val, act.oe, act.val);
   end
endtask

// single flags, uart rx and power off
task automatic check_bit(input string name, input logic exp, input logic act);
   check_count++;
   if (act !== exp) begin
      err_count++;
      $display("mismatch %s: expected %0b, actual %0b", name, exp, act);
   end
endtask

// failures that are not a value compare
task automatic report_failure(input string what);
   err_count++;
   $display("error: %s", what);
endtask

`endif

// ==== sim/tb_cw_io.sv ====
`timescale 1ns/1ps

module tb_cw_io;

   localparam logic [31:0] LFSR_SEED  = 32'h1f504af7;
   localparam logic [31:0] LFSR_TAPS  = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1
   localparam int          WAIT_LIMIT = 50;            // cycles per wait loop
   localparam int          POWER_LAT  = 2;             // write edge, then the power flop

   logic                                            clk_usb = 1'b0;
   logic                                            reset;
   logic [7:0]                                      reg_address;
   logic [cw_io_pkg::BYTECNT_W-1:0]                 reg_bytecnt;
   logic [7:0]                                      reg_datai;
   logic                                            reg_read;
   logic                                            reg_write;
   logic [7:0]                                      reg_datao;
   logic                                            aux_trig;
   logic                                            trigger_nrst;
   logic [3:0]                                      trigger_io;
   cw_io_pkg::trig_in_t                             trig_in;
   logic [3:0]                                      trig_out;  // trig, ext, dec, sad
   logic                                            uart_tx;
   logic                                            uart_rx;
   cw_io_pkg::pin_drive_t [cw_io_pkg::NUM_LANES-1:0] pin_drv;
   logic [cw_io_pkg::NUM_LANES-1:0]                 pin_level;
   logic [cw_io_pkg::NUM_LANES-1:0]                 ext_level;  // target side of each pad
   logic                                            targetpower_off;

   // expected register contents, kept from our own writes
   cw_io_pkg::trig_src_cfg_t                        trigsrc_sh;
   cw_io_pkg::trig_mod_cfg_t                        trigmod_sh;
   logic [63:0]                                     ioroute_sh;
   cw_io_pkg::io_route_t [cw_io_pkg::NUM_LANES-1:0] route_sh;
   logic                                            pwr_exp;
   logic                                            cmp_en;     // compare process on
   string                                           cur_test;
   logic [31:0]                                     lfsr_state;
   int                                              chk_mark;
   int                                              err_mark;

   `include "tb_cw_io_checks.svh"

   always #2 clk_usb = ~clk_usb;  // 4 ns period

   assign route_sh = ioroute_sh[cw_io_pkg::NUM_LANES*8-1:0];  // lane 1 in byte 0

   // pad resolution, driven value wins over the target side
   always_comb begin
      for (int i = 0; i < cw_io_pkg::NUM_LANES; i++) begin
         pin_level[i] = pin_drv[i].oe ? pin_drv[i].val : ext_level[i];
      end
   end

   cw_io_top i_cw_io_top (
      .clk_usb (clk_usb), .reset (reset),
      .reg_address_i (reg_address), .reg_bytecnt_i (reg_bytecnt), .reg_datai_i (reg_datai),
      .reg_read_i (reg_read), .reg_write_i (reg_write), .reg_datao_o (reg_datao),
      .aux_trig_i (aux_trig), .trigger_nrst_i (trigger_nrst), .trigger_io_i (trigger_io),
      .trig_in_i (trig_in), .trigger_o (trig_out[3]), .trigger_ext_o (trig_out[2]),
      .decodeio_active_o (trig_out[1]), .sad_active_o (trig_out[0]),
      .uart_tx_i (uart_tx), .uart_rx_o (uart_rx),
      .pin_o (pin_drv), .pin_level_i (pin_level), .targetpower_off_o (targetpower_off)
   );

   // galois lfsr, one step per bit taken
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   // masked combine of the six external sources
   function automatic logic ref_trigger(input cw_io_pkg::trig_src_cfg_t cfg, input logic [5:0] s);
      logic any_hi;
      logic all_hi;
      any_hi = 1'b0;
      all_hi = 1'b1;
      for (int i = 0; i < cw_io_pkg::NUM_TRIG_SRC; i++) begin
         if (cfg.src_en[i]) begin
            any_hi = any_hi | s[i];
            all_hi = all_hi & s[i];
         end
      end
      case (cfg.comb_mode)
         2'd0: return any_hi;
         2'd1: return all_hi;
         2'd2: return ~all_hi;
         default: return 1'b0;
      endcase
   endfunction

   // trigger module pick plus active flags
   function automatic logic [3:0] ref_select(input cw_io_pkg::trig_mod_cfg_t cfg, input logic ext,
                                             input cw_io_pkg::trig_in_t t);
      logic [7:0] pick;
      pick = {2'b00, t.adc, t.trace, t.decoded_io, t.sad, t.adv_io, ext};  // index by mode
      return {pick[cfg.mode], ext, cfg.mode == 3'd3, cfg.mode == 3'd2};
   endfunction

   function automatic cw_io_pkg::pin_drive_t ref_pin(input cw_io_pkg::io_route_t cfg,
                                                     input logic pwr, input logic tx);
      if (pwr) return 2'b00;  // unpowered target, all hi-z
      if (cfg.tx_sel) return {1'b1, tx};
      if (cfg.force_low) return 2'b10;
      if (cfg.usoc) return {~tx, 1'b0};  // open collector
      if (cfg.gpio_en) return {1'b1, cfg.gpio_val};
      return 2'b00;
   endfunction

   // lowest lane with rx_sel, idle high otherwise
   function automatic logic ref_rx(input cw_io_pkg::io_route_t [cw_io_pkg::NUM_LANES-1:0] cfg,
                                   input logic [cw_io_pkg::NUM_LANES-1:0] lvl);
      for (int i = 0; i < cw_io_pkg::NUM_LANES; i++) begin
         if (cfg[i].rx_sel) return lvl[i];
      end
      return 1'b1;
   endfunction

   function automatic logic [3:0] model_levels(input logic pwr, input logic tx,
                                               input logic [3:0] ext);
      cw_io_pkg::pin_drive_t d;
      logic [3:0]            lvl;
      for (int i = 0; i < cw_io_pkg::NUM_LANES; i++) begin
         d = ref_pin(route_sh[i], pwr, tx);
         lvl[i] = d.oe ? d.val : ext[i];
      end
      return lvl;
   endfunction

   // compare process, sampled on the rising edge half a cycle after the drive
   always @(posedge clk_usb) begin
      logic ext_exp;
      if (cmp_en) begin
         ext_exp = ref_trigger(trigsrc_sh, {trigger_io, trigger_nrst, aux_trig});
         check_trig(cur_test, ref_select(trigmod_sh, ext_exp, trig_in), trig_out);
         for (int i = 0; i < cw_io_pkg::NUM_LANES; i++) begin
            check_pin($sformatf("%s lane %0d", cur_test, i + 1),
                      ref_pin(route_sh[i], pwr_exp, uart_tx), pin_drv[i]);
         end
         check_bit({cur_test, " uart_rx"},
                   ref_rx(route_sh, model_levels(pwr_exp, uart_tx, ext_level)), uart_rx);
      end
   end

   // bus tasks are entered and left just after a falling edge
   task automatic write_reg(input logic [7:0] addr, input int cnt, input logic [7:0] data);
      cmp_en      = 1'b0;
      reg_read    = 1'b0;
      reg_write   = 1'b1;
      reg_address = addr;
      reg_bytecnt = cnt[cw_io_pkg::BYTECNT_W-1:0];
      reg_datai   = data;
      @(posedge clk_usb);
      @(negedge clk_usb);
      reg_write = 1'b0;
      if (addr == cw_io_pkg::ADDR_TRIGSRC) trigsrc_sh = data;
      if (addr == cw_io_pkg::ADDR_TRIGMOD) trigmod_sh = data;
      if (addr == cw_io_pkg::ADDR_IOROUTE && cnt < 8) ioroute_sh[cnt*8 +: 8] = data;
   endtask

   task automatic read_reg(input logic [7:0] addr, input int cnt, input logic [7:0] exp,
                           input string name);
      reg_write   = 1'b0;
      reg_read    = 1'b1;
      reg_address = addr;
      reg_bytecnt = cnt[cw_io_pkg::BYTECNT_W-1:0];
      @(posedge clk_usb);
      check_byte(name, exp, reg_datao);  // combinational read, same cycle
      @(negedge clk_usb);
      reg_read = 1'b0;
   endtask

   task automatic read_all(input string tag);
      read_reg(cw_io_pkg::ADDR_TRIGSRC, 0, trigsrc_sh, {tag, " trigsrc"});
      read_reg(cw_io_pkg::ADDR_TRIGMOD, 0, trigmod_sh, {tag, " trigmod"});
      for (int b = 0; b < 8; b++) begin
         read_reg(cw_io_pkg::ADDR_IOROUTE, b, ioroute_sh[b*8 +: 8],
                  $sformatf("%s ioroute byte %0d", tag, b));
      end
   endtask

   // one random input vector, checked by the compare process
   task automatic apply_cycle();
      aux_trig     = 1'(lfsr_bits(1));
      trigger_nrst = 1'(lfsr_bits(1));
      trigger_io   = 4'(lfsr_bits(4));
      trig_in      = cw_io_pkg::trig_in_t'(5'(lfsr_bits(5)));
      uart_tx      = 1'(lfsr_bits(1));
      ext_level    = 4'(lfsr_bits(4));
      cmp_en       = 1'b1;
      @(posedge clk_usb);
      @(negedge clk_usb);
      cmp_en = 1'b0;
   endtask

   task automatic wait_power(input logic level, output int cycles);
      cycles = 0;
      while (targetpower_off !== level && cycles < WAIT_LIMIT) begin
         @(posedge clk_usb);
         cycles++;
      end
      if (targetpower_off !== level) begin
         report_failure($sformatf("targetpower_off_o never went to %0b", level));
      end
      @(negedge clk_usb);
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      chk_mark = check_count;
      err_mark = err_count;
      test_count++;
   endtask

   task automatic end_test();
      $display("test %-12s done: %0d checks, %0d errors", cur_test,
               check_count - chk_mark, err_count - err_mark);
   endtask

   initial begin
      int         lat;
      logic [7:0] addr;
      logic [3:0] lvl_prev;
      lfsr_state   = LFSR_SEED;
      reset        = 1'b1;
      reg_address  = '0;
      reg_bytecnt  = '0;
      reg_datai    = '0;
      reg_read     = 1'b0;
      reg_write    = 1'b0;
      aux_trig     = 1'b0;
      trigger_nrst = 1'b1;
      trigger_io   = '0;
      trig_in      = '0;
      uart_tx      = 1'b1;  // uart idle
      ext_level    = '0;
      trigsrc_sh   = cw_io_pkg::TRIGSRC_RST;
      trigmod_sh   = cw_io_pkg::TRIGMOD_RST;
      ioroute_sh   = cw_io_pkg::IOROUTE_RST;
      pwr_exp      = 1'b0;
      cmp_en       = 1'b0;
      repeat (5) @(posedge clk_usb);
      @(negedge clk_usb);
      reset = 1'b0;

      start_test("reset_values");
      read_all("reset");
      read_reg(8'd12, 0, 8'h00, "reset unknown address");
      check_bit("reset power off", 1'b0, targetpower_off);
      repeat (4) apply_cycle();  // lanes 3 and 4 released
      end_test();

      start_test("reg_rw");
      write_reg(cw_io_pkg::ADDR_TRIGSRC, 0, 8'(lfsr_bits(8)));
      read_reg(cw_io_pkg::ADDR_TRIGSRC, 0, trigsrc_sh, "rw trigsrc");
      write_reg(cw_io_pkg::ADDR_TRIGMOD, 0, 8'(lfsr_bits(8)));
      read_reg(cw_io_pkg::ADDR_TRIGMOD, 0, trigmod_sh, "rw trigmod");
      for (int b = 0; b < 8; b++) begin
         write_reg(cw_io_pkg::ADDR_IOROUTE, b, 8'(lfsr_bits(8)));
         read_reg(cw_io_pkg::ADDR_IOROUTE, b, ioroute_sh[b*8 +: 8], "rw ioroute");
      end
      for (int n = 0; n < 8; n++) begin
         addr = 8'(lfsr_bits(8));
         if (!(addr inside {8'd39, 8'd40, 8'd55, 8'd56})) begin
            write_reg(addr, 0, 8'(lfsr_bits(8)));  // must be dropped
         end
      end
      read_all("after unknown writes");
      write_reg(cw_io_pkg::ADDR_IOROUTE, cw_io_pkg::IOROUTE_EXTRA_BYTE, 8'h00);  // power on
      wait_power(1'b0, lat);
      end_test();

      start_test("ext_trigger");
      write_reg(cw_io_pkg::ADDR_TRIGMOD, 0, 8'h00);  // edge mode, ext path on trigger_o
      for (int n = 0; n < 200; n++) begin
         write_reg(cw_io_pkg::ADDR_TRIGSRC, 0, 8'(lfsr_bits(8)));
         repeat (2) apply_cycle();
      end
      end_test();

      start_test("trig_select");
      for (int m = 0; m < 8; m++) begin
         write_reg(cw_io_pkg::ADDR_TRIGMOD, 0, {5'(lfsr_bits(5)), 3'(m)});
         repeat (6) apply_cycle();
      end
      end_test();

      start_test("io_routing");
      for (int n = 0; n < 40; n++) begin
         for (int b = 0; b < cw_io_pkg::NUM_LANES; b++) begin
            write_reg(cw_io_pkg::ADDR_IOROUTE, b, 8'(lfsr_bits(8)));
         end
         repeat (4) apply_cycle();
      end
      end_test();

      start_test("power_off");
      write_reg(cw_io_pkg::ADDR_IOROUTE, cw_io_pkg::IOROUTE_EXTRA_BYTE, 8'h02);
      wait_power(1'b1, lat);
      check_byte("power off latency", 8'(POWER_LAT), 8'(lat));
      for (int i = 0; i < cw_io_pkg::NUM_LANES; i++) begin
         check_pin($sformatf("power off lane %0d", i + 1), ref_pin(route_sh[i], 1'b1, uart_tx),
                   pin_drv[i]);
      end
      pwr_exp = 1'b1;
      repeat (4) apply_cycle();
      lvl_prev = model_levels(1'b1, uart_tx, ext_level);  // sampled at the last edge
      for (int n = 0; n < 8; n++) begin
         ext_level = 4'(lfsr_bits(4));
         read_reg(cw_io_pkg::ADDR_IOREAD, 0, {4'h0, lvl_prev}, "ioread");
         lvl_prev = model_levels(1'b1, uart_tx, ext_level);
      end
      write_reg(cw_io_pkg::ADDR_IOROUTE, cw_io_pkg::IOROUTE_EXTRA_BYTE, 8'h00);
      wait_power(1'b0, lat);
      pwr_exp = 1'b0;
      repeat (4) apply_cycle();  // drive comes back
      end_test();

      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
      if (err_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+sim
hw/cw_io_pkg.sv
hw/cw_regs.sv
hw/trigger_route.sv
hw/target_io_lane.sv
hw/io_gather.sv
hw/cw_io_top.sv
sim/tb_cw_io.sv
